/* Bender.yml */
package:
  name: simon_cipher

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/simonCipherPkg.sv
      - rtl/simonPacketPkg.sv
      - rtl/simonPacketIn.sv
      - rtl/simonKeySchedule.sv
      - rtl/simonRoundCore.sv
      - rtl/simonPacketOut.sv
      - rtl/simonCipherTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/simonChecker.sv
      - tests/simonTb.sv

/* build.f */
+incdir+rtl
rtl/simonCipherPkg.sv
rtl/simonPacketPkg.sv
rtl/simonPacketIn.sv
rtl/simonKeySchedule.sv
rtl/simonRoundCore.sv
rtl/simonPacketOut.sv
rtl/simonCipherTop.sv
tests/simonChecker.sv
tests/simonTb.sv

/* rtl/simonCipherPkg.sv */
`include "simon_consts.svh"

package simonCipherPkg;

	typedef logic [`SIMON_N-1:0] simonWord;

	// Index 1 is the upper half x, index 0 the lower half y
	typedef simonWord [1:0] simonBlock;

	typedef simonWord [`SIMON_M-1:0] simonKey;

	// Counts rounds 0 to 43, also used as round key address
	typedef logic [5:0] roundIdx;

endpackage

/* rtl/simonCipherTop.sv */
`timescale 1ns/10ps

module simonCipherTop
(
	input logic clk,
	input logic rstN,
	input logic pktReq,
	input simonPacketPkg::pktBytes pktIn,
	output logic pktLoad,
	output logic pktDone,
	output logic pktError,
	output logic outValid,
	output simonPacketPkg::pktBytes outPkt
);

logic newKey;
logic newData;
logic loadKey;
logic loadData;
logic keyReady;
logic coreBusy;
logic cipherValid;

simonCipherPkg::simonKey key;
simonCipherPkg::simonBlock dataBlock;
simonCipherPkg::simonBlock cipherBlock;
simonCipherPkg::simonWord roundKey;
simonCipherPkg::roundIdx round;
simonPacketPkg::pktCount blockCount;
simonPacketPkg::pktCount cipherCount;

simonPacketIn packetIn
(
	.clk(clk),
	.rstN(rstN),
	.pktReq(pktReq),
	.pktIn(pktIn),
	.coreBusy(coreBusy),
	.loadData(loadData),
	.loadKey(loadKey),
	.pktLoad(pktLoad),
	.pktDone(pktDone),
	.pktError(pktError),
	.newKey(newKey),
	.newData(newData),
	.key(key),
	.dataBlock(dataBlock),
	.blockCount(blockCount)
);

simonKeySchedule keySchedule
(
	.clk(clk),
	.rstN(rstN),
	.newKey(newKey),
	.key(key),
	.round(round),
	.loadKey(loadKey),
	.keyReady(keyReady),
	.roundKey(roundKey)
);

simonRoundCore roundCore
(
	.clk(clk),
	.rstN(rstN),
	.newData(newData),
	.dataBlock(dataBlock),
	.keyReady(keyReady),
	.blockCount(blockCount),
	.roundKey(roundKey),
	.loadData(loadData),
	.coreBusy(coreBusy),
	.round(round),
	.cipherValid(cipherValid),
	.cipherBlock(cipherBlock),
	.cipherCount(cipherCount)
);

simonPacketOut packetOut
(
	.clk(clk),
	.rstN(rstN),
	.cipherValid(cipherValid),
	.cipherBlock(cipherBlock),
	.cipherCount(cipherCount),
	.outValid(outValid),
	.outPkt(outPkt)
);

endmodule

/* rtl/simonKeySchedule.sv */
`timescale 1ns/10ps
`include "simon_consts.svh"

module simonKeySchedule
(
	input logic clk,
	input logic rstN,
	input logic newKey,
	input simonCipherPkg::simonKey key,
	input simonCipherPkg::roundIdx round,
	output logic loadKey,
	output logic keyReady,
	output simonCipherPkg::simonWord roundKey
);

// z3 sequence, bit j used for round key j+4
localparam logic [61:0] z3Seq = 62'b11110000101100111001010001001000000111101001100011010111011011;

simonCipherPkg::simonWord rk [`SIMON_T];
simonCipherPkg::roundIdx idx;	// Next key to compute
simonCipherPkg::simonWord tmp;
simonCipherPkg::simonWord nextKey;
logic expanding;
logic takeKey;

function automatic simonCipherPkg::simonWord rotRight(input simonCipherPkg::simonWord w,
	input int s);
	return (w >> s) | (w << (`SIMON_N - s));
endfunction

assign takeKey = newKey && !expanding && !loadKey;

always_comb
begin
	tmp = rotRight(rk[idx - 1], 3) ^ rk[idx - 3];
	nextKey = rk[idx - 4] ^ tmp ^ rotRight(tmp, 1) ^ 32'hFFFF_FFFC ^ z3Seq[idx - 4];
end

always_ff @(posedge clk, negedge rstN)
begin
	if (!rstN)
	begin
		loadKey <= 1'b0;
		keyReady <= 1'b0;
		expanding <= 1'b0;
		idx <= `SIMON_M;
	end
	else
	begin
		loadKey <= takeKey;
		if (takeKey)
		begin
			expanding <= 1'b1;
			keyReady <= 1'b0;
			idx <= `SIMON_M;
		end
		else if (expanding)
		begin
			if (idx == `SIMON_T)	// One settle cycle after the last key
			begin
				expanding <= 1'b0;
				keyReady <= 1'b1;
			end
			else
				idx <= idx + 1'b1;
		end
	end
end

always_ff @(posedge clk)
begin
	if (takeKey)
	begin
		for (int i = 0; i < `SIMON_M; i++)
			rk[i] <= key[i];
	end
	else if (expanding && idx != `SIMON_T)
		rk[idx] <= nextKey;
end

assign roundKey = rk[round];

roundInRange: assert property (@(posedge clk) disable iff (!rstN)
	round < `SIMON_T)
	else $error("round index past the last round key");

endmodule

/* rtl/simonPacketIn.sv */
`timescale 1ns/10ps
`include "simon_consts.svh"

module simonPacketIn
(
	input logic clk,
	input logic rstN,
	input logic pktReq,
	input simonPacketPkg::pktBytes pktIn,
	input logic coreBusy,
	input logic loadData,
	input logic loadKey,
	output logic pktLoad,
	output logic pktDone,
	output logic pktError,
	output logic newKey,
	output logic newData,
	output simonCipherPkg::simonKey key,
	output simonCipherPkg::simonBlock dataBlock,
	output simonPacketPkg::pktCount blockCount
);

simonPacketPkg::pktInState state;

simonPacketPkg::pktBytes pkt;
simonPacketPkg::infoByte info;
simonPacketPkg::pktCount count;
simonPacketPkg::pktCount expCount;
simonCipherPkg::simonWord [`SIMON_M-1:0] words;

logic reqDly;
logic reqPend;		// Rising pktReq seen, not yet loaded
logic busy;		// Accepted packet still has blocks to issue
logic secondBlk;
logic badPkt;
logic keyPkt;
logic twoBlock;
logic holdOff;

assign words = pkt[15:0];
assign count = pkt[16];
assign info = pkt[17];

assign badPkt = (info[3:0] != `SIMON_MODE) || (count != expCount) || info[4];
assign keyPkt = info[5];
assign twoBlock = info[7] && !keyPkt;

// Wait while either consumer still owns a strobe or the core is running
assign holdOff = coreBusy || newData || loadData || newKey || loadKey;

always_ff @(posedge clk, negedge rstN)
begin
	if (!rstN)
	begin
		state <= simonPacketPkg::sIdle;
		reqDly <= 1'b0;
		reqPend <= 1'b0;
		busy <= 1'b0;
		secondBlk <= 1'b0;
		expCount <= '0;
		pktLoad <= 1'b0;
		pktDone <= 1'b0;
		pktError <= 1'b0;
		newKey <= 1'b0;
		newData <= 1'b0;
	end
	else
	begin
		reqDly <= pktReq;
		pktLoad <= 1'b0;
		if (newData && loadData)
			newData <= 1'b0;
		if (newKey && loadKey)
			newKey <= 1'b0;

		unique case (state)
		simonPacketPkg::sIdle:
		begin
			if (busy)
			begin
				if (!holdOff)
					state <= simonPacketPkg::sIssue;
			end
			else if (reqPend)
				state <= simonPacketPkg::sLatch;
		end
		simonPacketPkg::sLatch:
		begin
			pktLoad <= 1'b1;
			pktDone <= 1'b0;
			reqPend <= 1'b0;
			state <= simonPacketPkg::sCheck;
		end
		simonPacketPkg::sCheck:
		begin
			expCount <= expCount + 1'b1;	// Advances for rejected packets too
			if (badPkt)
			begin
				pktError <= 1'b1;
				pktDone <= 1'b1;
			end
			else
				busy <= 1'b1;
			state <= simonPacketPkg::sIdle;
		end
		simonPacketPkg::sIssue:
		begin
			if (keyPkt)
				newKey <= 1'b1;
			else
				newData <= 1'b1;

			if (twoBlock && !secondBlk)
				secondBlk <= 1'b1;
			else
			begin
				secondBlk <= 1'b0;
				busy <= 1'b0;
				pktDone <= 1'b1;
			end
			state <= simonPacketPkg::sIdle;
		end
		endcase

		if (pktReq && !reqDly)
			reqPend <= 1'b1;
	end
end

always_ff @(posedge clk)
begin
	if (state == simonPacketPkg::sLatch)
		pkt <= pktIn;
	if (state == simonPacketPkg::sIssue)
	begin
		if (keyPkt)
			key <= words;
		else
		begin
			dataBlock <= secondBlk ? words[3:2] : words[1:0];
			blockCount <= count;
		end
	end
end

newDataIdle: assert property (@(posedge clk) disable iff (!rstN)
	$rose(newData) |-> !coreBusy)
	else $error("newData raised while the round core is busy");

endmodule

/* rtl/simonPacketOut.sv */
`timescale 1ns/10ps
`include "simon_consts.svh"

module simonPacketOut
(
	input logic clk,
	input logic rstN,
	input logic cipherValid,
	input simonCipherPkg::simonBlock cipherBlock,
	input simonPacketPkg::pktCount cipherCount,
	output logic outValid,
	output simonPacketPkg::pktBytes outPkt
);

// Mode with the output flag set
localparam simonPacketPkg::infoByte outInfo = {3'b000, 1'b1, `SIMON_MODE};

simonPacketPkg::pktBytes nextPkt;

always_comb
begin
	nextPkt = '0;
	nextPkt[7:0] = cipherBlock;	// Lower half in bytes 0-3
	nextPkt[16] = cipherCount;
	nextPkt[17] = outInfo;
end

always_ff @(posedge clk, negedge rstN)
begin
	if (!rstN)
		outValid <= 1'b0;
	else
		outValid <= cipherValid;
end

always_ff @(posedge clk)
begin
	if (cipherValid)
		outPkt <= nextPkt;
end

endmodule

/* rtl/simonPacketPkg.sv */
`include "simon_consts.svh"

package simonPacketPkg;

	// Bytes 0-15 data, 16 count, 17 info
	typedef logic [`SIMON_PKT_BYTES-1:0][7:0] pktBytes;

	// Info byte fields
	//   [3:0] mode
	//   [4]   output packet
	//   [5]   key packet
	//   [7]   two data blocks
	typedef logic [7:0] infoByte;

	typedef logic [7:0] pktCount;

	typedef enum logic [1:0]
	{
		sIdle,
		sLatch,
		sCheck,
		sIssue
	} pktInState;

endpackage

/* rtl/simonRoundCore.sv */
`timescale 1ns/10ps
`include "simon_consts.svh"

module simonRoundCore
(
	input logic clk,
	input logic rstN,
	input logic newData,
	input simonCipherPkg::simonBlock dataBlock,
	input logic keyReady,
	input simonPacketPkg::pktCount blockCount,
	input simonCipherPkg::simonWord roundKey,
	output logic loadData,
	output logic coreBusy,
	output simonCipherPkg::roundIdx round,
	output logic cipherValid,
	output simonCipherPkg::simonBlock cipherBlock,
	output simonPacketPkg::pktCount cipherCount
);

simonCipherPkg::simonWord x;	// Upper half
simonCipherPkg::simonWord y;
simonCipherPkg::simonWord fx;
logic startBlk;

function automatic simonCipherPkg::simonWord rotLeft(input simonCipherPkg::simonWord w,
	input int s);
	return (w << s) | (w >> (`SIMON_N - s));
endfunction

assign startBlk = newData && keyReady && !coreBusy;

// SIMON round function
assign fx = (rotLeft(x, 1) & rotLeft(x, 8)) ^ rotLeft(x, 2);

always_ff @(posedge clk, negedge rstN)
begin
	if (!rstN)
	begin
		loadData <= 1'b0;
		coreBusy <= 1'b0;
		round <= '0;
		cipherValid <= 1'b0;
	end
	else
	begin
		loadData <= startBlk;
		cipherValid <= 1'b0;
		if (startBlk)
		begin
			coreBusy <= 1'b1;
			round <= '0;
		end
		else if (coreBusy)
		begin
			if (round == `SIMON_T - 1)
			begin
				coreBusy <= 1'b0;
				cipherValid <= 1'b1;
				round <= '0;
			end
			else
				round <= round + 1'b1;
		end
	end
end

always_ff @(posedge clk)
begin
	if (startBlk)
	begin
		x <= dataBlock[1];
		y <= dataBlock[0];
		cipherCount <= blockCount;	// Rides along with the block
	end
	else if (coreBusy)
	begin
		x <= y ^ fx ^ roundKey;
		y <= x;
	end
end

assign cipherBlock = {x, y};

loadNeedsKey: assert property (@(posedge clk) disable iff (!rstN)
	loadData |-> keyReady)
	else $error("block taken without a ready key schedule");

endmodule

/* rtl/simon_consts.svh */
`ifndef SIMON_CONSTS_SVH
`define SIMON_CONSTS_SVH

// SIMON 64/128
`define SIMON_N 32
`define SIMON_M 4
`define SIMON_T 44

// Packet layout: 16 data bytes, count byte, info byte
`define SIMON_PKT_BYTES 18

// Expected mode in info[3:0]
`define SIMON_MODE 4'h3

`endif

/* tests/simonChecker.sv */
`timescale 1ns/10ps

module simonChecker
#(
	parameter int numPkts = 40
)
(
	input logic clk,
	input logic rstN,
	input logic pktLoad,
	input logic pktDone,
	input logic pktError,
	input logic outValid,
	input simonPacketPkg::pktBytes outPkt,
	input logic expValid,
	input simonPacketPkg::pktBytes expPkt,
	input logic errExpected,
	input logic stimDone,
	output logic runOver,
	output logic timedOut,
	output int errorCount
);

localparam int cycleLimit = numPkts * 150;
localparam int drainCycles = 100;	// Long enough for a stray block to surface

simonPacketPkg::pktBytes expQ [$];
int cycles = 0;
int drain = 0;
int mismatches = 0;
int extras = 0;
int missing = 0;
int compared = 0;
int errTotal = 0;
logic over = 1'b0;
logic tOut = 1'b0;
logic rstSeen = 1'b0;
logic errExpSeen = 1'b0;
logic doneDly = 1'b0;

assign runOver = over;
assign timedOut = tOut;
assign errorCount = errTotal;

task automatic reportMismatch(input string name, input logic [63:0] got,
	input logic [63:0] want);
	$display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
	mismatches++;
endtask

task automatic checkOutput();
	simonPacketPkg::pktBytes want;
	if (expQ.size() == 0)
	begin
		$display("** Error at %0t: output packet arrived while none was expected", $time);
		extras++;
	end
	else
	begin
		want = expQ.pop_front();
		compared++;
		if (outPkt[7:0] !== want[7:0])
			reportMismatch("outPkt ciphertext", outPkt[7:0], want[7:0]);
		if (outPkt[15:8] !== want[15:8])
			reportMismatch("outPkt padding", outPkt[15:8], want[15:8]);
		if (outPkt[16] !== want[16])
			reportMismatch("outPkt count", outPkt[16], want[16]);
		if (outPkt[17] !== want[17])
			reportMismatch("outPkt info", outPkt[17], want[17]);
	end
endtask

task automatic printSummary();
	missing = expQ.size();
	if (missing != 0)
		$display("** Error: %0d expected output packets never arrived", missing);
	errTotal = mismatches + extras + missing;
	$display("Checker: %0d errors (%0d mismatches, %0d missing, %0d extra), %0d packets compared",
		errTotal, mismatches, missing, extras, compared);
endtask

// Inputs driven on the falling edge settle by the rising edge
always @(posedge clk)
begin
	rstSeen = rstN;
	errExpSeen = errExpected;
	if (expValid)
		expQ.push_back(expPkt);
end

always @(negedge clk)
begin
	cycles++;
	if (!rstSeen)
	begin
		if (pktLoad !== 1'b0)
			reportMismatch("pktLoad", pktLoad, 0);
		if (pktDone !== 1'b0)
			reportMismatch("pktDone", pktDone, 0);
		if (pktError !== 1'b0)
			reportMismatch("pktError", pktError, 0);
		if (outValid !== 1'b0)
			reportMismatch("outValid", outValid, 0);
	end
	else if (!over && !tOut)
	begin
		// Sticky error level must track the rejected packets so far
		if (pktDone && !doneDly && pktError !== errExpSeen)
			reportMismatch("pktError", pktError, errExpSeen);
		if (outValid)
			checkOutput();

		if (stimDone && expQ.size() == 0)
			drain++;
		if (cycles >= cycleLimit)
		begin
			$display("Run timed out after %0d cycles with %0d output packets outstanding",
				cycles, expQ.size());
			printSummary();
			tOut = 1'b1;
		end
		else if (drain >= drainCycles)
		begin
			printSummary();
			over = 1'b1;
		end
	end
	doneDly = pktDone;
end

endmodule

/* tests/simonTb.sv */
`timescale 1ns/10ps
`include "simon_consts.svh"

module simonTb;

localparam int numPkts = 40;

logic clk;
logic rstN;
logic pktReq;
simonPacketPkg::pktBytes pktIn;
logic pktLoad;
logic pktDone;
logic pktError;
logic outValid;
simonPacketPkg::pktBytes outPkt;

logic expValid;
simonPacketPkg::pktBytes expPkt;
logic errExpected;
logic stimDone;
logic runOver;
logic timedOut;
int errorCount;

integer seed;
int pktNum;
simonCipherPkg::simonWord rk [`SIMON_T];	// Model round keys

simonCipherTop dut
(
	.clk(clk),
	.rstN(rstN),
	.pktReq(pktReq),
	.pktIn(pktIn),
	.pktLoad(pktLoad),
	.pktDone(pktDone),
	.pktError(pktError),
	.outValid(outValid),
	.outPkt(outPkt)
);

simonChecker #(.numPkts(numPkts)) check
(
	.clk(clk),
	.rstN(rstN),
	.pktLoad(pktLoad),
	.pktDone(pktDone),
	.pktError(pktError),
	.outValid(outValid),
	.outPkt(outPkt),
	.expValid(expValid),
	.expPkt(expPkt),
	.errExpected(errExpected),
	.stimDone(stimDone),
	.runOver(runOver),
	.timedOut(timedOut),
	.errorCount(errorCount)
);

initial
begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

function automatic simonCipherPkg::simonWord rotateLeft(input simonCipherPkg::simonWord w,
	input int s);
	return (w << s) | (w >> (32 - s));
endfunction

task automatic expandKey(input simonCipherPkg::simonKey k);
	simonCipherPkg::simonWord t;
	logic [63:0] z;
	z = 64'hfc2c_e512_07a6_35db;	// z3 sequence with bit 0 used first
	for (int i = 0; i < `SIMON_M; i++)
		rk[i] = k[i];
	for (int i = `SIMON_M; i < `SIMON_T; i++)
	begin
		t = rotateLeft(rk[i - 1], 29) ^ rk[i - 3];	// Right by 3
		rk[i] = rk[i - 4] ^ t ^ rotateLeft(t, 31) ^ 32'hFFFF_FFFC ^ z[i - 4];
	end
endtask

// Expected output packet for one plaintext block with x in the upper word
task automatic encryptBlock(input logic [63:0] blk, input simonPacketPkg::pktCount c,
	output simonPacketPkg::pktBytes p);
	simonCipherPkg::simonWord x;
	simonCipherPkg::simonWord y;
	simonCipherPkg::simonWord t;
	x = blk[63:32];
	y = blk[31:0];
	for (int i = 0; i < `SIMON_T; i++)
	begin
		t = x;
		x = y ^ ((rotateLeft(x, 1) & rotateLeft(x, 8)) ^ rotateLeft(x, 2)) ^ rk[i];
		y = t;
	end
	p = '0;
	p[3:0] = y;
	p[7:4] = x;
	p[16] = c;
	p[17] = {4'b0001, `SIMON_MODE};
endtask

task automatic pushExpected(input simonPacketPkg::pktBytes p);
	expPkt = p;
	expValid = 1'b1;
	@(negedge clk);
	expValid = 1'b0;
endtask

task automatic sendPacket(input simonPacketPkg::pktBytes p);
	pktIn = p;
	pktReq = 1'b1;
	@(negedge clk);
	while (!pktLoad)
		@(negedge clk);
	pktReq = 1'b0;
	@(negedge clk);
	while (!pktDone)
		@(negedge clk);
endtask

// Packet kind 0 key, 1 one block, 2 two blocks, 3 bad mode, 4 bad count, 5 output flag set
task automatic runPacket(input int kind, input logic [127:0] data);
	simonPacketPkg::pktBytes p;
	simonPacketPkg::pktBytes want;
	simonPacketPkg::pktCount c;
	simonPacketPkg::infoByte info;
	logic [31:0] r;
	r = $random(seed);
	c = pktNum[7:0];
	info = {r[7], r[6], 2'b00, `SIMON_MODE};
	case (kind)
	0: info[5] = 1'b1;
	1: info[7] = 1'b0;
	2: info[7] = 1'b1;
	3: info[3:0] = `SIMON_MODE ^ (r[11:8] | 4'h1);
	4: c = c ^ (r[23:16] | 8'h01);
	default: info[4] = 1'b1;
	endcase
	if (kind >= 3)
		info[5] = r[5];	// Rejected key packets must leave the key alone
	p = {info, c, data};

	if (kind == 0)
		expandKey(data);
	else if (kind <= 2)
	begin
		encryptBlock(data[63:0], c, want);
		pushExpected(want);
		if (kind == 2)
		begin
			encryptBlock(data[127:64], c, want);
			pushExpected(want);
		end
	end
	else
		errExpected = 1'b1;
	sendPacket(p);
	pktNum++;
endtask

initial
begin
	simonPacketPkg::pktBytes kat;
	logic [127:0] data;
	int v;
	int kind;
	seed = 32'hf5d5_890e;
	rstN = 1'b0;
	pktReq = 1'b0;
	pktIn = '0;
	expValid = 1'b0;
	expPkt = '0;
	errExpected = 1'b0;
	stimDone = 1'b0;
	pktNum = 0;
	repeat (8) @(negedge clk);
	rstN = 1'b1;
	repeat (2) @(negedge clk);

	// Published SIMON 64/128 vector
	runPacket(0, {32'h1b1a1918, 32'h13121110, 32'h0b0a0908, 32'h03020100});
	kat = '0;
	kat[3:0] = 32'hb9dfa07a;
	kat[7:4] = 32'h44c8fc20;
	kat[16] = pktNum[7:0];
	kat[17] = {4'b0001, `SIMON_MODE};
	pushExpected(kat);
	sendPacket({4'b0000, `SIMON_MODE, pktNum[7:0], 64'h0, 32'h656b696c, 32'h20646e75});
	pktNum++;

	for (int i = 0; i < numPkts - 2; i++)
	begin
		v = $random(seed) & 15;
		if (i == 8)
			kind = 0;	// Guaranteed rekey mid-run
		else if (i == 10 || i == 12 || i == 14)
			kind = 3 + (i - 10) / 2;
		else if (v < 2)
			kind = 0;
		else if (v == 2)
			kind = 3 + (($random(seed) & 32'h7fff_ffff) % 3);
		else if (v < 10)
			kind = 1;
		else
			kind = 2;
		data = {$random(seed), $random(seed), $random(seed), $random(seed)};
		runPacket(kind, data);
	end

	stimDone = 1'b1;
	wait (runOver);
	@(posedge clk);
	if (errorCount == 0)
		$display("PASS: all tests");
	else
		$display("FAIL: see errors above");
	$finish;
end

initial
begin
	wait (timedOut);
	$display("FAIL: see errors above");
	$finish;
end

endmodule
